// ==== cart_pkg.sv ====
package cart_pkg;

  localparam int CPU_ADDR_W   = 24;
  localparam int ROM_ADDR_W   = 24;
  localparam int BSRAM_ADDR_W = 20;
  localparam int DATA_W       = 8;

  localparam logic [DATA_W-1:0] OPEN_BUS = 8'hff; // Nothing drives the bus.

  // LoROM save RAM lives in banks 70 through 7D.
  localparam logic [7:0] LOROM_SRAM_BANK_LO = 8'h70;
  localparam logic [7:0] LOROM_SRAM_BANK_HI = 8'h7d;

  localparam logic [15:0] MSU_BASE = 16'h2000;
  localparam logic [2:0]  MSU_REV  = 3'd1;

  // ID string "S-MSU1".
  localparam logic [DATA_W-1:0] MSU_ID0 = 8'h53;
  localparam logic [DATA_W-1:0] MSU_ID1 = 8'h2d;
  localparam logic [DATA_W-1:0] MSU_ID2 = 8'h4d;
  localparam logic [DATA_W-1:0] MSU_ID3 = 8'h53;
  localparam logic [DATA_W-1:0] MSU_ID4 = 8'h55;
  localparam logic [DATA_W-1:0] MSU_ID5 = 8'h31;

  typedef struct packed {
    logic [7:0]  bank;
    logic        a15;
    logic [14:0] offset; // 32K page offset.
  } lorom_addr_t;

  typedef struct packed {
    logic [7:0]  bank;
    logic [15:0] offset; // Full 64K bank offset.
  } hirom_addr_t;

  // Same CPU address seen by both mapping schemes.
  typedef union packed {
    lorom_addr_t lo;
    hirom_addr_t hi;
  } cpu_addr_u;

  typedef struct packed {
    cpu_addr_u         addr;
    logic [DATA_W-1:0] wdata;
    logic              rd;
    logic              wr;
    logic              rom_sel;
    logic              stb;     // Registered sysclkf_ce.
  } cpu_bus_t;

  typedef struct packed {
    logic [ROM_ADDR_W-1:0]   rom_addr;
    logic                    rom_hit;
    logic [BSRAM_ADDR_W-1:0] bsram_addr;
    logic                    bsram_hit;
    logic                    rd;
    logic                    wr;
    logic [DATA_W-1:0]       wdata;
  } mem_req_t;

  typedef struct packed {
    logic [15:0]       track_num;
    logic              track_request;
    logic [DATA_W-1:0] volume;
    logic              repeat_en;
    logic              playing;
  } msu_out_t;

endpackage

// ==== cpu_bus_capture.sv ====
`timescale 1ns/1ps

module cpu_bus_capture (
  input  logic                             mclk,
  input  logic                             rst_n,
  input  logic [cart_pkg::CPU_ADDR_W-1:0]  ca,
  input  logic                             cpurd_n,
  input  logic                             cpuwr_n,
  input  logic                             romsel_n,
  input  logic [cart_pkg::DATA_W-1:0]      cpu_wdata,
  input  logic                             sysclkf_ce,
  output cart_pkg::cpu_bus_t               bus_q
);

  // Address and data are payload only.
  always_ff @(posedge mclk) begin
    bus_q.addr  <= ca;
    bus_q.wdata <= cpu_wdata;
  end

  // Strobes go active high here.
  always_ff @(posedge mclk) begin
    if (!rst_n) begin
      bus_q.rd      <= 1'b0;
      bus_q.wr      <= 1'b0;
      bus_q.rom_sel <= 1'b0;
      bus_q.stb     <= 1'b0;
    end else begin
      bus_q.rd      <= ~cpurd_n;
      bus_q.wr      <= ~cpuwr_n;
      bus_q.rom_sel <= ~romsel_n;
      bus_q.stb     <= sysclkf_ce; // One mclk per CPU cycle.
    end
  end

endmodule

// ==== lhrom_mapper.sv ====
`timescale 1ns/1ps

module lhrom_mapper (
  input  logic                               mclk,
  input  logic                               rst_n,
  input  cart_pkg::cpu_bus_t                 bus_q,
  input  logic [7:0]                         map_ctrl,
  input  logic [cart_pkg::ROM_ADDR_W-1:0]    rom_mask,
  input  logic [cart_pkg::BSRAM_ADDR_W-1:0]  ram_mask,
  output cart_pkg::mem_req_t                 req_q
);

  logic                               hirom;
  logic                               lo_sram_bank;
  logic                               hi_sram_win;
  logic                               bsram_hit;
  logic                               rom_hit;
  logic [cart_pkg::ROM_ADDR_W-1:0]    rom_addr;
  logic [cart_pkg::BSRAM_ADDR_W-1:0]  bsram_addr;

  assign hirom = map_ctrl[0]; // Bit 0 picks HiROM.

  assign lo_sram_bank = (bus_q.addr.lo.bank >= cart_pkg::LOROM_SRAM_BANK_LO) &&
                        (bus_q.addr.lo.bank <= cart_pkg::LOROM_SRAM_BANK_HI);

  // Banks 20-3F and A0-BF at 6000-7FFF.
  assign hi_sram_win = (bus_q.addr.hi.bank[6:5] == 2'b01) &&
                       (bus_q.addr.hi.offset[15:13] == 3'b011);

  always_comb begin
    if (hirom) begin
      bsram_hit  = hi_sram_win;
      bsram_addr = {2'b00, bus_q.addr.hi.bank[4:0], bus_q.addr.hi.offset[12:0]};
      rom_addr   = {2'b00, bus_q.addr.hi.bank[5:0], bus_q.addr.hi.offset};
    end else begin
      // Lower half of the bank only.
      bsram_hit  = bus_q.rom_sel && lo_sram_bank && !bus_q.addr.lo.a15;
      bsram_addr = {1'b0, bus_q.addr.lo.bank[3:0], bus_q.addr.lo.offset};
      rom_addr   = {2'b00, bus_q.addr.lo.bank[6:0], bus_q.addr.lo.offset};
    end
    rom_hit = bus_q.rom_sel && !bsram_hit; // Save RAM shadows ROM.
  end

  always_ff @(posedge mclk) begin
    req_q.rom_addr   <= rom_addr & rom_mask;
    req_q.bsram_addr <= bsram_addr & ram_mask;
    req_q.wdata      <= bus_q.wdata;
  end

  always_ff @(posedge mclk) begin
    if (!rst_n) begin
      req_q.rom_hit   <= 1'b0;
      req_q.bsram_hit <= 1'b0;
      req_q.rd        <= 1'b0;
      req_q.wr        <= 1'b0;
    end else begin
      req_q.rom_hit   <= rom_hit;
      req_q.bsram_hit <= bsram_hit;
      req_q.rd        <= bus_q.rd;
      req_q.wr        <= bus_q.wr;
    end
  end

endmodule

// ==== msu_regs.sv ====
`timescale 1ns/1ps

module msu_regs (
  input  logic                         mclk,
  input  logic                         rst_n,
  input  cart_pkg::cpu_bus_t           bus_q,
  input  logic                         msu_enable,
  input  logic                         msu_track_missing,
  input  logic                         msu_track_mounting,
  input  logic                         msu_audio_stop,
  output logic [cart_pkg::DATA_W-1:0]  msu_rdata,
  output logic                         msu_sel,
  output cart_pkg::msu_out_t           msu_out
);

  logic [15:0] offset;
  logic [2:0]  reg_idx;
  logic        wr_en;

  assign offset  = bus_q.addr.hi.offset;
  assign reg_idx = offset[2:0];

  // Eight byte window at 2000 in banks 00-3F and 80-BF.
  assign msu_sel = msu_enable && (bus_q.rd || bus_q.wr) && !bus_q.addr.hi.bank[6] &&
                   (offset[15:3] == cart_pkg::MSU_BASE[15:3]);

  assign wr_en = msu_sel && bus_q.wr && bus_q.stb;

  always_ff @(posedge mclk) begin
    if (!rst_n) begin
      msu_out.track_num     <= 16'h0000;
      msu_out.track_request <= 1'b0;
      msu_out.volume        <= '0;
      msu_out.repeat_en     <= 1'b0;
      msu_out.playing       <= 1'b0;
    end else begin
      msu_out.track_request <= 1'b0;
      if (wr_en) begin
        case (reg_idx)
          3'd4: msu_out.track_num[7:0] <= bus_q.wdata;
          3'd5: begin
            msu_out.track_num[15:8] <= bus_q.wdata;
            msu_out.track_request   <= 1'b1; // High byte commits the track.
          end
          3'd6: msu_out.volume <= bus_q.wdata;
          3'd7: begin
            msu_out.playing   <= bus_q.wdata[0];
            msu_out.repeat_en <= bus_q.wdata[1];
          end
          default: ;
        endcase
      end
      if (msu_audio_stop) begin
        msu_out.playing <= 1'b0; // Stop overrides a play write.
      end
    end
  end

  always_comb begin
    case (reg_idx)
      3'd0: msu_rdata = {1'b0, msu_track_mounting, msu_track_missing,
                         msu_out.playing, msu_out.repeat_en, cart_pkg::MSU_REV};
      3'd1: msu_rdata = '0; // No data stream.
      3'd2: msu_rdata = cart_pkg::MSU_ID0;
      3'd3: msu_rdata = cart_pkg::MSU_ID1;
      3'd4: msu_rdata = cart_pkg::MSU_ID2;
      3'd5: msu_rdata = cart_pkg::MSU_ID3;
      3'd6: msu_rdata = cart_pkg::MSU_ID4;
      default: msu_rdata = cart_pkg::MSU_ID5;
    endcase
  end

endmodule

// ==== bus_output_mux.sv ====
`timescale 1ns/1ps

module bus_output_mux (
  input  cart_pkg::mem_req_t                 req_q,
  input  logic [15:0]                        rom_q,
  input  logic [cart_pkg::DATA_W-1:0]        bsram_q,
  input  logic [cart_pkg::DATA_W-1:0]        msu_rdata,
  input  logic                               msu_sel,
  output logic [cart_pkg::ROM_ADDR_W-1:0]    rom_addr,
  output logic                               rom_ce_n,
  output logic                               rom_oe_n,
  output logic [cart_pkg::BSRAM_ADDR_W-1:0]  bsram_addr,
  output logic [cart_pkg::DATA_W-1:0]        bsram_d,
  output logic                               bsram_ce_n,
  output logic                               bsram_oe_n,
  output logic                               bsram_we_n,
  output logic [cart_pkg::DATA_W-1:0]        cpu_rdata
);

  assign rom_addr = req_q.rom_addr;
  assign rom_ce_n = ~req_q.rom_hit;
  assign rom_oe_n = ~(req_q.rom_hit & req_q.rd);

  assign bsram_addr = req_q.bsram_addr;
  assign bsram_d    = req_q.wdata;
  assign bsram_ce_n = ~req_q.bsram_hit;
  assign bsram_oe_n = ~(req_q.bsram_hit & req_q.rd);
  assign bsram_we_n = ~(req_q.bsram_hit & req_q.wr);

  always_comb begin
    if (msu_sel) begin
      cpu_rdata = msu_rdata;
    end else if (req_q.bsram_hit) begin
      cpu_rdata = bsram_q;
    end else if (req_q.rom_hit) begin
      // 16-bit ROM word and A0 picks the byte.
      cpu_rdata = req_q.rom_addr[0] ? rom_q[15:8] : rom_q[7:0];
    end else begin
      cpu_rdata = cart_pkg::OPEN_BUS;
    end
  end

endmodule

// ==== cart_slot_top.sv ====
`timescale 1ns/1ps

module cart_slot_top (
  input  logic                               mclk,
  input  logic                               rst_n,
  input  logic [cart_pkg::CPU_ADDR_W-1:0]    ca,
  input  logic                               cpurd_n,
  input  logic                               cpuwr_n,
  input  logic                               romsel_n,
  input  logic [cart_pkg::DATA_W-1:0]        cpu_wdata,
  input  logic                               sysclkf_ce,
  input  logic [7:0]                         map_ctrl,
  input  logic [cart_pkg::ROM_ADDR_W-1:0]    rom_mask,
  input  logic [cart_pkg::BSRAM_ADDR_W-1:0]  ram_mask,
  output logic [cart_pkg::ROM_ADDR_W-1:0]    rom_addr,
  input  logic [15:0]                        rom_q,
  output logic                               rom_ce_n,
  output logic                               rom_oe_n,
  output logic [cart_pkg::BSRAM_ADDR_W-1:0]  bsram_addr,
  output logic [cart_pkg::DATA_W-1:0]        bsram_d,
  input  logic [cart_pkg::DATA_W-1:0]        bsram_q,
  output logic                               bsram_ce_n,
  output logic                               bsram_oe_n,
  output logic                               bsram_we_n,
  output logic [cart_pkg::DATA_W-1:0]        cpu_rdata,
  input  logic                               msu_enable,
  input  logic                               msu_track_missing,
  input  logic                               msu_track_mounting,
  input  logic                               msu_audio_stop,
  output logic [15:0]                        msu_track_num,
  output logic                               msu_track_request,
  output logic [cart_pkg::DATA_W-1:0]        msu_volume,
  output logic                               msu_audio_repeat,
  output logic                               msu_audio_playing
);

  cart_pkg::cpu_bus_t          bus_q;
  cart_pkg::mem_req_t          req_q;
  logic [cart_pkg::DATA_W-1:0] msu_rdata;
  logic                        msu_sel;

  cpu_bus_capture u_capture (
    .mclk       (mclk),
    .rst_n      (rst_n),
    .ca         (ca),
    .cpurd_n    (cpurd_n),
    .cpuwr_n    (cpuwr_n),
    .romsel_n   (romsel_n),
    .cpu_wdata  (cpu_wdata),
    .sysclkf_ce (sysclkf_ce),
    .bus_q      (bus_q)
  );

  lhrom_mapper u_mapper (
    .mclk     (mclk),
    .rst_n    (rst_n),
    .bus_q    (bus_q),
    .map_ctrl (map_ctrl),
    .rom_mask (rom_mask),
    .ram_mask (ram_mask),
    .req_q    (req_q)
  );

  // Concatenation follows msu_out_t field order.
  msu_regs u_msu (
    .mclk               (mclk),
    .rst_n              (rst_n),
    .bus_q              (bus_q),
    .msu_enable         (msu_enable),
    .msu_track_missing  (msu_track_missing),
    .msu_track_mounting (msu_track_mounting),
    .msu_audio_stop     (msu_audio_stop),
    .msu_rdata          (msu_rdata),
    .msu_sel            (msu_sel),
    .msu_out            ({msu_track_num, msu_track_request, msu_volume,
                          msu_audio_repeat, msu_audio_playing})
  );

  bus_output_mux u_out_mux (
    .req_q      (req_q),
    .rom_q      (rom_q),
    .bsram_q    (bsram_q),
    .msu_rdata  (msu_rdata),
    .msu_sel    (msu_sel),
    .rom_addr   (rom_addr),
    .rom_ce_n   (rom_ce_n),
    .rom_oe_n   (rom_oe_n),
    .bsram_addr (bsram_addr),
    .bsram_d    (bsram_d),
    .bsram_ce_n (bsram_ce_n),
    .bsram_oe_n (bsram_oe_n),
    .bsram_we_n (bsram_we_n),
    .cpu_rdata  (cpu_rdata)
  );

endmodule

// ==== cart_slot_tb.sv ====
`timescale 1ns/1ps

module cart_slot_tb;

  localparam int ACCESSES   = 60;
  localparam int MAX_CYCLES = 6 * ACCESSES * 4 + 560; // Six tests of 4-cycle accesses.

  typedef struct packed {
    logic        rom_hit;
    logic [23:0] rom_addr;
    logic        bsram_hit;
    logic [19:0] bsram_addr;
  } map_exp_t;

  logic        mclk;
  logic        rst_n;
  logic [23:0] ca;
  logic        cpurd_n;
  logic        cpuwr_n;
  logic        romsel_n;
  logic [7:0]  cpu_wdata;
  logic        sysclkf_ce;
  logic [7:0]  map_ctrl;
  logic [23:0] rom_mask;
  logic [19:0] ram_mask;
  logic [23:0] rom_addr;
  logic [15:0] rom_q;
  logic        rom_ce_n;
  logic        rom_oe_n;
  logic [19:0] bsram_addr;
  logic [7:0]  bsram_d;
  logic [7:0]  bsram_q;
  logic        bsram_ce_n;
  logic        bsram_oe_n;
  logic        bsram_we_n;
  logic [7:0]  cpu_rdata;
  logic        msu_enable;
  logic        msu_track_missing;
  logic        msu_track_mounting;
  logic        msu_audio_stop;
  logic [15:0] msu_track_num;
  logic        msu_track_request;
  logic [7:0]  msu_volume;
  logic        msu_audio_repeat;
  logic        msu_audio_playing;

  integer      seed;
  int          errors, checks, cycles, tests_run;
  int          test_checks0, test_errors0;
  int          pulses, exp_pulses, req_run;
  logic [15:0] m_track;
  logic [7:0]  m_volume;
  logic        m_playing;
  logic        m_repeat;

  cart_slot_top u_dut (
    .mclk (mclk), .rst_n (rst_n), .ca (ca), .cpurd_n (cpurd_n), .cpuwr_n (cpuwr_n),
    .romsel_n (romsel_n), .cpu_wdata (cpu_wdata), .sysclkf_ce (sysclkf_ce),
    .map_ctrl (map_ctrl), .rom_mask (rom_mask), .ram_mask (ram_mask),
    .rom_addr (rom_addr), .rom_q (rom_q), .rom_ce_n (rom_ce_n), .rom_oe_n (rom_oe_n),
    .bsram_addr (bsram_addr), .bsram_d (bsram_d), .bsram_q (bsram_q),
    .bsram_ce_n (bsram_ce_n), .bsram_oe_n (bsram_oe_n), .bsram_we_n (bsram_we_n),
    .cpu_rdata (cpu_rdata), .msu_enable (msu_enable), .msu_track_missing (msu_track_missing),
    .msu_track_mounting (msu_track_mounting), .msu_audio_stop (msu_audio_stop),
    .msu_track_num (msu_track_num), .msu_track_request (msu_track_request),
    .msu_volume (msu_volume), .msu_audio_repeat (msu_audio_repeat),
    .msu_audio_playing (msu_audio_playing)
  );

  // Memory contents mix every address bit.
  function automatic logic [15:0] rom_word(input logic [23:0] a);
    return {a[7:0] ^ a[23:16] ^ 8'h5a, a[15:8] ^ {a[3:0], a[7:4]} ^ 8'hc3};
  endfunction

  function automatic logic [7:0] bsram_byte(input logic [19:0] a);
    return a[7:0] ^ a[15:8] ^ {a[19:16], a[11:8]} ^ 8'h96;
  endfunction

  function automatic logic [31:0] next_rand();
    next_rand = $random(seed);
  endfunction

  function automatic map_exp_t map_expect(input logic [23:0] a, input logic romsel,
                                          input logic hirom);
    map_exp_t e;
    if (hirom) begin
      e.bsram_hit  = (a[22:21] == 2'b01) && (a[15:13] == 3'b011); // 6000-7FFF window.
      e.bsram_addr = {2'b00, a[20:16], a[12:0]} & ram_mask;
      e.rom_addr   = {2'b00, a[21:0]} & rom_mask;
    end else begin
      e.bsram_hit  = romsel && (a[23:16] >= cart_pkg::LOROM_SRAM_BANK_LO) &&
                     (a[23:16] <= cart_pkg::LOROM_SRAM_BANK_HI) && !a[15];
      e.bsram_addr = {1'b0, a[19:16], a[14:0]} & ram_mask;
      e.rom_addr   = {2'b00, a[22:16], a[14:0]} & rom_mask;
    end
    e.rom_hit = romsel && !e.bsram_hit;
    return e;
  endfunction

  function automatic logic msu_hit(input logic [23:0] a, input logic rd, input logic wr);
    return msu_enable && (rd || wr) && !a[22] && (a[15:0] >= cart_pkg::MSU_BASE) &&
           (a[15:0] <= cart_pkg::MSU_BASE + 16'd7);
  endfunction

  function automatic logic [7:0] msu_byte(input logic [2:0] idx);
    case (idx)
      3'd0: return {1'b0, msu_track_mounting, msu_track_missing, m_playing, m_repeat,
                    cart_pkg::MSU_REV};
      3'd1: return 8'h00;
      3'd2: return cart_pkg::MSU_ID0;
      3'd3: return cart_pkg::MSU_ID1;
      3'd4: return cart_pkg::MSU_ID2;
      3'd5: return cart_pkg::MSU_ID3;
      3'd6: return cart_pkg::MSU_ID4;
      default: return cart_pkg::MSU_ID5;
    endcase
  endfunction

  assign rom_q   = rom_word(rom_addr);
  assign bsram_q = bsram_byte(bsram_addr);

  always #2 mclk = ~mclk;

  always @(posedge mclk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run still busy after %0d cycles", cycles);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // Request pulse width, sampled mid-cycle.
  always @(negedge mclk) begin
    if (msu_track_request === 1'b1) begin
      req_run++;
    end else if (req_run != 0) begin
      assert (req_run == 1) else begin
        $display("Track request pulse lasted %0d cycles instead of one", req_run);
        errors++;
      end
      pulses++;
      req_run = 0;
    end
  end

  task automatic next_cycle();
    @(posedge mclk);
    #0.5;
  endtask

  task automatic check_val(input string name, input logic [23:0] got, input logic [23:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("ERR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_val(name, 24'(got), 24'(exp));
  endtask

  task automatic idle_checks();
    check_bit("rom_ce_n", rom_ce_n, 1'b1);
    check_bit("rom_oe_n", rom_oe_n, 1'b1);
    check_bit("bsram_ce_n", bsram_ce_n, 1'b1);
    check_bit("bsram_oe_n", bsram_oe_n, 1'b1);
    check_bit("bsram_we_n", bsram_we_n, 1'b1);
    check_bit("msu_track_request", msu_track_request, 1'b0);
    check_bit("msu_audio_playing", msu_audio_playing, 1'b0);
  endtask

  task automatic update_msu_model();
    if (msu_hit(ca, ~cpurd_n, ~cpuwr_n) && !cpuwr_n) begin
      case (ca[2:0])
        3'd4: m_track[7:0] = cpu_wdata;
        3'd5: begin
          m_track[15:8] = cpu_wdata;
          exp_pulses++;
        end
        3'd6: m_volume = cpu_wdata;
        3'd7: begin
          m_playing = cpu_wdata[0];
          m_repeat  = cpu_wdata[1];
        end
        default: ;
      endcase
    end
    if (msu_audio_stop) m_playing = 1'b0;
  endtask

  task automatic check_outputs();
    map_exp_t    e;
    logic        rd;
    logic        wr;
    logic [15:0] w;
    logic [7:0]  exp_rd;
    rd = ~cpurd_n;
    wr = ~cpuwr_n;
    e  = map_expect(ca, ~romsel_n, map_ctrl[0]);
    check_bit("rom_ce_n", rom_ce_n, !e.rom_hit);
    check_bit("rom_oe_n", rom_oe_n, !(e.rom_hit && rd));
    check_bit("bsram_ce_n", bsram_ce_n, !e.bsram_hit);
    check_bit("bsram_oe_n", bsram_oe_n, !(e.bsram_hit && rd));
    check_bit("bsram_we_n", bsram_we_n, !(e.bsram_hit && wr));
    if (e.rom_hit) check_val("rom_addr", rom_addr, e.rom_addr);
    if (e.bsram_hit) check_val("bsram_addr", 24'(bsram_addr), 24'(e.bsram_addr));
    if (e.bsram_hit && wr) check_val("bsram_d", 24'(bsram_d), 24'(cpu_wdata));
    if (rd) begin
      if (msu_hit(ca, rd, wr)) begin
        exp_rd = msu_byte(ca[2:0]);
      end else if (e.bsram_hit) begin
        exp_rd = bsram_byte(e.bsram_addr);
      end else if (e.rom_hit) begin
        w      = rom_word(e.rom_addr);
        exp_rd = e.rom_addr[0] ? w[15:8] : w[7:0]; // Odd address takes the high byte.
      end else begin
        exp_rd = cart_pkg::OPEN_BUS;
      end
      check_val("cpu_rdata", 24'(cpu_rdata), 24'(exp_rd));
    end
    check_val("msu_track_num", 24'(msu_track_num), 24'(m_track));
    check_val("msu_volume", 24'(msu_volume), 24'(m_volume));
    check_bit("msu_audio_playing", msu_audio_playing, m_playing);
    check_bit("msu_audio_repeat", msu_audio_repeat, m_repeat);
    check_bit("msu_track_request", msu_track_request, 1'b0);
  endtask

  // Bus held 4 cycles with one CE strobe, outputs checked in the last one.
  task automatic bus_access(input logic [23:0] addr, input logic rd, input logic wr,
                            input logic romsel, input logic [7:0] wdata);
    ca         = addr;
    cpurd_n    = ~rd;
    cpuwr_n    = ~wr;
    romsel_n   = ~romsel;
    cpu_wdata  = wdata;
    sysclkf_ce = 1'b1;
    next_cycle();
    sysclkf_ce = 1'b0;
    next_cycle();
    next_cycle();
    update_msu_model();
    check_outputs();
    next_cycle();
  endtask

  task automatic random_masks();
    logic [31:0] r;
    r        = next_rand();
    rom_mask = 24'hffffff >> (r[7:0] % 5);
    ram_mask = 20'hfffff >> (r[15:8] % 4);
  endtask

  task automatic start_test();
    test_checks0 = checks;
    test_errors0 = errors;
  endtask

  task automatic report_test(input int num, input string name);
    tests_run++;
    $display("test %0d %s: %0d checks, %0d errors", num, name,
             checks - test_checks0, errors - test_errors0);
  endtask

  task automatic reset_state_test();
    int i;
    for (i = 0; i < 10; i++) begin
      next_cycle();
      idle_checks();
    end
    rst_n = 1'b1;
    for (i = 0; i < 3; i++) begin
      next_cycle();
      idle_checks();
    end
  endtask

  task automatic lorom_read_test();
    int          i;
    logic [31:0] r;
    map_ctrl = 8'h00;
    for (i = 0; i < ACCESSES; i++) begin
      r = next_rand();
      random_masks();
      bus_access({r[23:16], 1'b1, r[14:0]}, 1'b1, 1'b0, 1'b1, 8'h00);
    end
  endtask

  task automatic hirom_map_test();
    int          i;
    logic [31:0] r;
    map_ctrl = 8'h01;
    for (i = 0; i < ACCESSES / 3; i++) begin
      r = next_rand();
      random_masks();
      bus_access({2'b11, r[21:0]}, 1'b1, 1'b0, 1'b1, 8'h00);
      bus_access({r[23], 2'b01, r[20:16], 3'b011, r[12:0]}, 1'b1, 1'b0, 1'b0, 8'h00);
      bus_access({r[23], 2'b00, r[20:16], 1'b0, r[14:0]}, 1'b1, 1'b0, 1'b0, 8'h00);
    end
  endtask

  task automatic bsram_write_test();
    int          i;
    logic [31:0] r;
    map_ctrl = 8'h00;
    for (i = 0; i < ACCESSES; i++) begin
      r = next_rand();
      random_masks();
      bus_access({8'h70 + 8'(r % 14), 1'b0, r[14:0]}, 1'b0, 1'b1, 1'b1, r[23:16]);
    end
  endtask

  task automatic msu_write_test();
    int          i;
    logic [31:0] r;
    map_ctrl   = 8'h00;
    msu_enable = 1'b1;
    for (i = 0; i < 8; i++) bus_access(24'h002000 + 24'(i), 1'b1, 1'b0, 1'b0, 8'h00);
    msu_track_mounting = 1'b1;
    msu_track_missing  = 1'b1;
    bus_access(24'h802000, 1'b1, 1'b0, 1'b0, 8'h00); // Bank 80 mirror.
    msu_track_mounting = 1'b0;
    for (i = 0; i < 4; i++) begin
      r = next_rand();
      bus_access(24'h002004, 1'b0, 1'b1, 1'b0, r[7:0]);
      bus_access(24'h002005, 1'b0, 1'b1, 1'b0, r[15:8]);
      check_val("msu_track_request pulses", 24'(pulses), 24'(exp_pulses));
    end
    r = next_rand();
    bus_access(24'h002006, 1'b0, 1'b1, 1'b0, r[7:0]);
    for (i = 1; i < 4; i++) begin
      bus_access(24'h002007, 1'b0, 1'b1, 1'b0, 8'(i));
      bus_access(24'h002000, 1'b1, 1'b0, 1'b0, 8'h00);
    end
    msu_audio_stop = 1'b1;
    next_cycle();
    msu_audio_stop = 1'b0;
    m_playing      = 1'b0;
    next_cycle();
    check_bit("msu_audio_playing", msu_audio_playing, 1'b0);
    check_bit("msu_audio_repeat", msu_audio_repeat, m_repeat);
    msu_audio_stop = 1'b1; // Held across a play write.
    bus_access(24'h002007, 1'b0, 1'b1, 1'b0, 8'h01);
    msu_audio_stop = 1'b0;
    bus_access(24'h002000, 1'b1, 1'b0, 1'b0, 8'h00);
  endtask

  task automatic msu_disabled_test();
    int          i;
    logic [31:0] r;
    msu_enable = 1'b0;
    for (i = 0; i < 8; i++) bus_access(24'h002000 + 24'(i), 1'b1, 1'b0, 1'b0, 8'h00);
    for (i = 4; i < 8; i++) begin
      r = next_rand();
      bus_access(24'h002000 + 24'(i), 1'b0, 1'b1, 1'b0, r[7:0]);
    end
    check_val("msu_track_request pulses", 24'(pulses), 24'(exp_pulses));
  endtask

  initial begin
    mclk = 1'b0;
    rst_n = 1'b0;
    ca = '0;
    cpurd_n = 1'b1;
    cpuwr_n = 1'b1;
    romsel_n = 1'b1;
    cpu_wdata = '0;
    sysclkf_ce = 1'b0;
    map_ctrl = '0;
    rom_mask = '1;
    ram_mask = '1;
    msu_enable = 1'b0;
    msu_track_missing = 1'b0;
    msu_track_mounting = 1'b0;
    msu_audio_stop = 1'b0;
    seed = 32'h6fa1bfe3;
    {errors, checks, cycles, tests_run, pulses, exp_pulses, req_run} = '0;
    m_track = '0;
    m_volume = '0;
    m_playing = 1'b0;
    m_repeat = 1'b0;

    start_test();
    reset_state_test();
    report_test(1, "reset_state");
    start_test();
    lorom_read_test();
    report_test(2, "lorom_reads");
    start_test();
    hirom_map_test();
    report_test(3, "hirom_mapping");
    start_test();
    bsram_write_test();
    report_test(4, "bsram_writes");
    start_test();
    msu_write_test();
    report_test(5, "msu_writes");
    start_test();
    msu_disabled_test();
    report_test(6, "msu_disabled");

    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== cart_slot.f ====
cart_pkg.sv
cpu_bus_capture.sv
lhrom_mapper.sv
msu_regs.sv
bus_output_mux.sv
cart_slot_top.sv
cart_slot_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the cartridge slot testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module cart_slot_tb \
  -f cart_slot.f \
  -o cart_slot_sim

sim_out=$(./obj_dir/cart_slot_sim)
echo "$sim_out"

if grep -qF "*** TEST PASSED ***" <<< "$sim_out"; then
  exit 0
else
  exit 1
fi
